/* files.f */
hw/rvPkg.sv
hw/aluUnit.sv
hw/immDecode.sv
hw/regFile.sv
hw/wordMemory.sv
hw/multiCycleControl.sv
hw/rvDatapath.sv
hw/rvCoreTop.sv
dv/rvCoreSva.sv
dv/retireChecker.sv
dv/rvCoreTb.sv

/* dv/rvCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module rvCoreTb import rvPkg::*; ();

    localparam int          MemWords = 256;
    localparam int          AddrW    = $clog2(MemWords) + 2;
    localparam logic [31:0] DataAddr = 32'h204;
    localparam logic [31:0] DataWord = 32'h5a3c_e1f7;

    logic             clk;
    logic             rstN;
    logic             run;
    logic             progWe;
    logic [AddrW-1:0] progAddr;
    logic [31:0]      progData;
    retireInfo_t      retire;

    int          mismatches;
    int          retired;
    int          nRows;
    int          cycles;
    int          seed = 32'heb08;
    logic [31:0] xr [32]; // Expected register contents
    logic [31:0] pc;
    logic [31:0] loadAddr[$];
    logic [31:0] loadWord[$];

    rvCoreTop #(.MemWords(MemWords)) dut0 (
        .clk     (clk),
        .rstN    (rstN),
        .run     (run),
        .progWe  (progWe),
        .progAddr(progAddr),
        .progData(progData),
        .retire  (retire)
    );

    retireChecker checker0 (
        .clk       (clk),
        .rstN      (rstN),
        .retire    (retire),
        .mismatches(mismatches),
        .retired   (retired)
    );

    always #2 clk = ~clk;

    always @(negedge clk) cycles++;

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OpcOp};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OpcStore};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OpcBranch};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OpcJal};
    endfunction

    // Adds one executed instruction and its expected retire record
    task automatic addRow(input string name, input logic [31:0] word, input logic rdWe,
                          input logic [31:0] rdData, input logic [31:0] nextPc,
                          input logic memWe = 1'b0, input logic illegal = 1'b0);
        retireInfo_t rec;
        rec.valid   = 1'b1;
        rec.pc      = pc;
        rec.nextPc  = nextPc;
        rec.rdWe    = rdWe;
        rec.rd      = word[11:7];
        rec.rdData  = rdData;
        rec.memWe   = memWe;
        rec.illegal = illegal;
        checker0.pushExpected(name, rec);
        loadAddr.push_back(pc);
        loadWord.push_back(word);
        if (rdWe && word[11:7] != 5'd0) begin
            xr[word[11:7]] = rdData;
        end
        pc = nextPc;
        nRows++;
    endtask

    task automatic addSeq(input string name, input logic [31:0] word,
                          input logic [31:0] rdData);
        addRow(name, word, 1'b1, rdData, pc + 32'd4);
    endtask

    task automatic addBranch(input string name, input logic [2:0] f3, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic taken);
        addRow(name, encB(13'd8, rs2, rs1, f3), 1'b0, 32'd0, taken ? pc + 32'd8 : pc + 32'd4);
    endtask

    task automatic buildProgram();
        int          immA;
        int          immB;
        logic [31:0] simm;
        logic [31:0] target;
        pc    = '0;
        nRows = 0;
        for (int i = 0; i < 32; i++) begin
            xr[i] = '0;
        end
        immA = -1 - ($random(seed) & 32'h7ff); // Negative so SRA and SLT differ from SRL and SLTU
        immB = ($random(seed) & 32'h7ff) | 32'h1; // Positive with a nonzero shift amount
        simm = immB;
        addSeq("ADDI x1", encI(immA[11:0], 0, 3'b000, 1, OpcOpImm), immA);
        addSeq("ADDI x2", encI(immB[11:0], 0, 3'b000, 2, OpcOpImm), immB);
        addSeq("ADD", encR(7'h00, 2, 1, 3'b000, 3), xr[1] + xr[2]);
        addSeq("SUB", encR(7'h20, 2, 1, 3'b000, 4), xr[1] - xr[2]);
        addSeq("AND", encR(7'h00, 2, 1, 3'b111, 5), xr[1] & xr[2]);
        addSeq("OR", encR(7'h00, 2, 1, 3'b110, 6), xr[1] | xr[2]);
        addSeq("XOR", encR(7'h00, 2, 1, 3'b100, 7), xr[1] ^ xr[2]);
        addSeq("SLT", encR(7'h00, 2, 1, 3'b010, 8), 32'($signed(xr[1]) < $signed(xr[2])));
        addSeq("SLTU", encR(7'h00, 2, 1, 3'b011, 9), 32'(xr[1] < xr[2]));
        addSeq("SLL", encR(7'h00, 2, 1, 3'b001, 10), xr[1] << xr[2][4:0]);
        addSeq("SRL", encR(7'h00, 2, 1, 3'b101, 11), xr[1] >> xr[2][4:0]);
        addSeq("SRA", encR(7'h20, 2, 1, 3'b101, 12), $signed(xr[1]) >>> xr[2][4:0]);
        addSeq("ANDI", encI(immB[11:0], 1, 3'b111, 13, OpcOpImm), xr[1] & simm);
        addSeq("ORI", encI(immB[11:0], 1, 3'b110, 14, OpcOpImm), xr[1] | simm);
        addSeq("XORI", encI(immB[11:0], 1, 3'b100, 15, OpcOpImm), xr[1] ^ simm);
        addSeq("SLTI", encI(immB[11:0], 1, 3'b010, 16, OpcOpImm),
               32'($signed(xr[1]) < $signed(simm)));
        addSeq("SLTIU", encI(immB[11:0], 1, 3'b011, 17, OpcOpImm), 32'(xr[1] < simm));
        addSeq("SLLI", encI(12'h007, 1, 3'b001, 18, OpcOpImm), xr[1] << 7);
        addSeq("SRLI", encI(12'h009, 1, 3'b101, 19, OpcOpImm), xr[1] >> 9);
        addSeq("SRAI", encI(12'h409, 1, 3'b101, 20, OpcOpImm), $signed(xr[1]) >>> 9);
        addSeq("ADDI x0", encI(12'd5, 1, 3'b000, 0, OpcOpImm), xr[1] + 32'd5);
        addSeq("ADD from x0", encR(7'h00, 1, 0, 3'b000, 21), xr[0] + xr[1]);
        addSeq("ADDI base", encI(12'h200, 0, 3'b000, 22, OpcOpImm), 32'h200);
        addRow("SW", encS(12'd0, 1, 22), 1'b0, 32'd0, pc + 32'd4, 1'b1);
        addSeq("LW stored", encI(12'd0, 22, 3'b010, 23, OpcLoad), xr[1]);
        addSeq("LW preloaded", encI(12'd4, 22, 3'b010, 24, OpcLoad), DataWord);
        addSeq("ADDI x25", encI(12'hffd, 0, 3'b000, 25, OpcOpImm), -3);
        addSeq("ADDI x26", encI(12'd5, 0, 3'b000, 26, OpcOpImm), 5);
        addBranch("BEQ taken", 3'b000, 26, 26, xr[26] == xr[26]);
        addBranch("BEQ not taken", 3'b000, 25, 26, xr[25] == xr[26]);
        addBranch("BNE taken", 3'b001, 25, 26, xr[25] != xr[26]);
        addBranch("BNE not taken", 3'b001, 26, 26, xr[26] != xr[26]);
        addBranch("BLT taken", 3'b100, 25, 26, $signed(xr[25]) < $signed(xr[26]));
        addBranch("BLT not taken", 3'b100, 26, 25, $signed(xr[26]) < $signed(xr[25]));
        addBranch("BGE taken", 3'b101, 26, 25, $signed(xr[26]) >= $signed(xr[25]));
        addBranch("BGE not taken", 3'b101, 25, 26, $signed(xr[25]) >= $signed(xr[26]));
        addBranch("BLTU taken", 3'b110, 26, 25, xr[26] < xr[25]);
        addBranch("BLTU not taken", 3'b110, 25, 26, xr[25] < xr[26]);
        addBranch("BGEU taken", 3'b111, 25, 26, xr[25] >= xr[26]);
        addBranch("BGEU not taken", 3'b111, 26, 25, xr[26] >= xr[25]);
        addRow("JAL", encJ(21'd8, 27), 1'b1, pc + 32'd4, pc + 32'd8);
        target = pc + 32'd17; // Odd target so JALR must drop bit zero
        addSeq("ADDI x28", encI(target[11:0], 0, 3'b000, 28, OpcOpImm), target);
        addRow("JALR", encI(12'd0, 28, 3'b000, 29, OpcJalr), 1'b1, pc + 32'd4,
               xr[28] & ~32'd1);
        addRow("unknown opcode", 32'h0000_007f, 1'b0, 32'd0, pc + 32'd4, 1'b0, 1'b1);
        addSeq("ADD last", encR(7'h00, 23, 21, 3'b000, 30), xr[21] + xr[23]);
        loadAddr.push_back(DataAddr); // Data section
        loadWord.push_back(DataWord);
    endtask

    task automatic loadMemory();
        for (int i = 0; i < loadAddr.size(); i++) begin
            @(posedge clk);
            #1;
            progWe   = 1'b1;
            progAddr = loadAddr[i][AddrW-1:0];
            progData = loadWord[i];
        end
        @(posedge clk);
        #1 progWe = 1'b0;
    endtask

    initial begin
        int limit;
        int missing;
        int timeouts;
        int failures;
        clk      = 1'b0;
        rstN     = 1'b1;
        run      = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        buildProgram();
        limit = 8 + loadAddr.size() + 2 + nRows * 4 + 20;
        #1 rstN = 1'b0;
        repeat (8) @(posedge clk);
        #1 rstN = 1'b1;
        loadMemory();
        @(posedge clk);
        #1 run = 1'b1;
        while (retired < nRows && cycles < limit) begin
            @(posedge clk);
        end
        #1 run = 1'b0;
        timeouts = (retired < nRows) ? 1 : 0;
        if (timeouts != 0) begin
            $display("Timeout after %0d cycles, only %0d of %0d instructions retired",
                     cycles, retired, nRows);
        end
        repeat (2) @(posedge clk);
        missing  = nRows - retired;
        failures = mismatches + missing + timeouts + dut0.control0.sva0.assertFails;
        $display("Error counts: %0d mismatches, %0d missing retires, %0d timeouts, %0d asserts",
                 mismatches, missing, timeouts, dut0.control0.sva0.assertFails);
        if (failures == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/retireChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module retireChecker import rvPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  retireInfo_t retire,
    output int          mismatches,
    output int          retired
);

    string       expName[$];
    retireInfo_t expRec[$];
    int          cycle;
    int          lastRetire;

    task automatic pushExpected(input string name, input retireInfo_t rec);
        expName.push_back(name);
        expRec.push_back(rec);
    endtask

    task automatic checkField(input string name, input string field,
                              input logic [31:0] expVal, input logic [31:0] actVal);
        if (actVal !== expVal) begin
            mismatches++;
            $display("** Error %s %s: expected %h, actual %h", name, field, expVal, actVal);
        end
    endtask

    initial begin
        mismatches = 0;
        retired    = 0;
        cycle      = 0;
        lastRetire = -1;
    end

    // Sampled mid cycle, retire changes only on the rising edge
    always @(negedge clk) begin
        retireInfo_t want;
        string       name;
        cycle++;
        if (rstN && retire.valid) begin
            if (lastRetire >= 0 && cycle - lastRetire != 4) begin
                mismatches++;
                $display("Retire pulses came %0d cycles apart instead of 4",
                         cycle - lastRetire);
            end
            lastRetire = cycle;
            if (expRec.size() == 0) begin
                mismatches++;
                $display("Unexpected retire at pc %h after the last instruction", retire.pc);
            end else begin
                want = expRec.pop_front();
                name = expName.pop_front();
                checkField(name, "pc", want.pc, retire.pc);
                checkField(name, "nextPc", want.nextPc, retire.nextPc);
                checkField(name, "rdWe", 32'(want.rdWe), 32'(retire.rdWe));
                if (want.rdWe) begin
                    checkField(name, "rd", 32'(want.rd), 32'(retire.rd));
                    checkField(name, "rdData", want.rdData, retire.rdData);
                end
                checkField(name, "memWe", 32'(want.memWe), 32'(retire.memWe));
                checkField(name, "illegal", 32'(want.illegal), 32'(retire.illegal));
                retired++;
            end
        end
    end

endmodule

`default_nettype wire

/* dv/rvCoreSva.sv */
`timescale 1ns/1ps
`default_nettype none

module rvCoreSva import rvPkg::*; (
    input logic     clk,
    input logic     rstN,
    input logic     run,
    input phase_t   phase,
    input ctrlSig_t ctrl
);

    int assertFails = 0;

    resetPhase: assert property (@(posedge clk) !rstN |-> phase == PhaseIf)
        else begin
            assertFails++;
            $error("Phase is not IF while reset is asserted");
        end

    // IF, ID, EX, WB and back to IF
    phaseOrder: assert property (@(posedge clk) disable iff (!rstN)
        run |=> phase == phase_t'($past(phase) + 2'd1))
        else begin
            assertFails++;
            $error("Phase did not advance in order");
        end

    phaseHold: assert property (@(posedge clk) disable iff (!rstN)
        !run |=> phase == $past(phase))
        else begin
            assertFails++;
            $error("Phase moved while run was low");
        end

    idleStrobes: assert property (@(posedge clk)
        !run |-> !(ctrl.pcWe || ctrl.irWe || ctrl.regWe || ctrl.memWe))
        else begin
            assertFails++;
            $error("Strobe active while the core is idle");
        end

    // One retire per four cycles
    pcWeSpacing: assert property (@(posedge clk) disable iff (!rstN || !run)
        ctrl.pcWe |=> !ctrl.pcWe [*3] ##1 ctrl.pcWe)
        else begin
            assertFails++;
            $error("PC update strobes are not four cycles apart");
        end

endmodule

bind multiCycleControl rvCoreSva sva0 (
    .clk  (clk),
    .rstN (rstN),
    .run  (run),
    .phase(phase),
    .ctrl (ctrl)
);

`default_nettype wire

/* hw/rvCoreTop.sv */
`timescale 1ns/1ps
`default_nettype none

module rvCoreTop import rvPkg::*; #(
    parameter  int MemWords = 256,
    localparam int AddrW    = $clog2(MemWords) + 2
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             run,
    input  logic             progWe,
    input  logic [AddrW-1:0] progAddr,
    input  logic [31:0]      progData,
    output retireInfo_t      retire
);

    instrWord_u       instr;
    logic             cond;
    ctrlSig_t         ctrl;
    phase_t           phase;
    logic [AddrW-1:0] memAddr;
    logic [31:0]      memWdata;
    logic [31:0]      memRdata;
    logic             memWe;

    multiCycleControl control0 (
        .clk  (clk),
        .rstN (rstN),
        .run  (run),
        .instr(instr),
        .cond (cond),
        .ctrl (ctrl),
        .phase(phase)
    );

    rvDatapath #(.MemWords(MemWords)) datapath0 (
        .clk     (clk),
        .rstN    (rstN),
        .ctrl    (ctrl),
        .phase   (phase),
        .instr   (instr),
        .cond    (cond),
        .memAddr (memAddr),
        .memWdata(memWdata),
        .memWe   (memWe),
        .memRdata(memRdata),
        .retire  (retire)
    );

    wordMemory #(.MemWords(MemWords)) memory0 (
        .clk     (clk),
        .addr    (memAddr),
        .wdata   (memWdata),
        .we      (memWe),
        .progWe  (progWe),
        .progAddr(progAddr),
        .progData(progData),
        .rdata   (memRdata)
    );

endmodule

`default_nettype wire

/* hw/rvDatapath.sv */
`timescale 1ns/1ps
`default_nettype none

module rvDatapath import rvPkg::*; #(
    parameter  int MemWords = 256,
    localparam int AddrW    = $clog2(MemWords) + 2
) (
    input  logic             clk,
    input  logic             rstN,
    input  ctrlSig_t         ctrl,
    input  phase_t           phase,
    output instrWord_u       instr,
    output logic             cond,
    output logic [AddrW-1:0] memAddr,
    output logic [31:0]      memWdata,
    output logic             memWe,
    input  logic [31:0]      memRdata,
    output retireInfo_t      retire
);

    logic [31:0] pc;
    logic [31:0] aReg, bReg, linkReg, resultReg;
    logic [31:0] rdata1, rdata2;
    logic [31:0] imm;
    logic [31:0] aluA, aluB, aluResult;
    logic        aluCond;
    logic [31:0] wbData;
    logic [31:0] nextPc;
    logic        illegal;

    regFile regs0 (
        .clk   (clk),
        .rstN  (rstN),
        .rs1   (instr.r.rs1),
        .rs2   (instr.r.rs2),
        .rd    (instr.r.rd),
        .we    (ctrl.regWe),
        .wdata (wbData),
        .rdata1(rdata1),
        .rdata2(rdata2)
    );

    immDecode imm0 (.instr(instr), .imm(imm));

    aluUnit alu0 (.op(ctrl.aluOp), .a(aluA), .b(aluB), .result(aluResult), .cond(aluCond));

    assign aluA = (ctrl.aSel == ASelRs1) ? aReg : pc;
    assign aluB = (ctrl.bSel == BSelRs2) ? bReg :
                  (ctrl.bSel == BSelImm) ? imm : 32'd4;
    assign cond = ctrl.isBranch & aluCond;

    assign wbData = (ctrl.wbSel == WbMem)  ? memRdata :
                    (ctrl.wbSel == WbLink) ? linkReg : resultReg;

    // Bit zero cleared for JALR, a no-op for the even branch and JAL targets
    assign nextPc = (ctrl.pcSel == PcTarget) ? {resultReg[31:1], 1'b0} : linkReg;

    assign memAddr  = (phase == PhaseIf) ? pc[AddrW-1:0] : resultReg[AddrW-1:0];
    assign memWdata = bReg;
    assign memWe    = ctrl.memWe;

    always_comb begin
        case (instr.r.opcode)
            OpcOp, OpcOpImm, OpcLoad, OpcStore, OpcBranch, OpcJal, OpcJalr: illegal = 1'b0;
            default: illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc    <= '0;
            instr <= '0;
        end else begin
            if (ctrl.irWe) instr <= memRdata;
            if (ctrl.pcWe) pc <= nextPc;
        end
    end

    always_ff @(posedge clk) begin
        if (phase == PhaseId) begin
            aReg    <= rdata1;
            bReg    <= rdata2;
            linkReg <= aluResult; // PC plus four
        end
        if (phase == PhaseEx) resultReg <= aluResult;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            retire <= '0;
        end else begin
            retire.valid   <= ctrl.pcWe; // Only high in WB
            retire.pc      <= pc;
            retire.nextPc  <= nextPc;
            retire.rdWe    <= ctrl.regWe;
            retire.rd      <= instr.r.rd;
            retire.rdData  <= wbData;
            retire.memWe   <= ctrl.memWe;
            retire.illegal <= illegal;
        end
    end

endmodule

`default_nettype wire

/* hw/multiCycleControl.sv */
`timescale 1ns/1ps
`default_nettype none

module multiCycleControl import rvPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       run,
    input  instrWord_u instr,
    input  logic       cond,
    output ctrlSig_t   ctrl,
    output phase_t     phase
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    aluOp_t     arithOp;
    aluOp_t     branchOp;

    assign opcode = instr.r.opcode;
    assign funct3 = instr.r.funct3;
    assign funct7 = instr.r.funct7;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase <= PhaseIf;
        end else if (run) begin
            phase <= phase_t'(phase + 2'd1); // Wraps WB back to IF
        end
    end

    always_comb begin
        case (funct3)
            3'b000:  arithOp = (opcode == OpcOp && funct7[5]) ? AluSub : AluAdd;
            3'b001:  arithOp = AluSll;
            3'b010:  arithOp = AluSlt;
            3'b011:  arithOp = AluSltu;
            3'b100:  arithOp = AluXor;
            3'b101:  arithOp = funct7[5] ? AluSra : AluSrl; // Also imm[10] for SRAI
            3'b110:  arithOp = AluOr;
            default: arithOp = AluAnd;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b001:  branchOp = AluNe;
            3'b100:  branchOp = AluLt;
            3'b101:  branchOp = AluGe;
            3'b110:  branchOp = AluLtu;
            3'b111:  branchOp = AluGeu;
            default: branchOp = AluEq;
        endcase
    end

    always_comb begin
        ctrl       = '0;
        ctrl.aSel  = ASelPc;
        ctrl.bSel  = BSelFour;
        ctrl.aluOp = AluAdd; // PC plus four in ID
        ctrl.wbSel = WbAlu;
        ctrl.pcSel = PcSeq;
        case (phase)
            PhaseIf: ctrl.irWe = 1'b1;
            PhaseEx: begin
                case (opcode)
                    OpcOp: begin
                        ctrl.aSel  = ASelRs1;
                        ctrl.bSel  = BSelRs2;
                        ctrl.aluOp = arithOp;
                    end
                    OpcOpImm: begin
                        ctrl.aSel  = ASelRs1;
                        ctrl.bSel  = BSelImm;
                        ctrl.aluOp = arithOp;
                    end
                    OpcLoad, OpcStore, OpcJalr: begin
                        ctrl.aSel = ASelRs1; // Base plus offset
                        ctrl.bSel = BSelImm;
                    end
                    OpcBranch, OpcJal: ctrl.bSel = BSelImm; // PC relative target
                    default: ;
                endcase
            end
            PhaseWb: begin
                ctrl.pcWe = 1'b1;
                case (opcode)
                    OpcOp, OpcOpImm: ctrl.regWe = 1'b1;
                    OpcLoad: begin
                        ctrl.regWe = 1'b1;
                        ctrl.wbSel = WbMem;
                    end
                    OpcStore: ctrl.memWe = 1'b1;
                    OpcBranch: begin
                        // Compare rs1 and rs2 while the target waits in the result reg
                        ctrl.aSel     = ASelRs1;
                        ctrl.bSel     = BSelRs2;
                        ctrl.aluOp    = branchOp;
                        ctrl.isBranch = 1'b1;
                        ctrl.pcSel    = cond ? PcTarget : PcSeq;
                    end
                    OpcJal, OpcJalr: begin
                        ctrl.regWe = 1'b1;
                        ctrl.wbSel = WbLink;
                        ctrl.pcSel = PcTarget;
                    end
                    default: ; // Unknown opcode falls through as a no-op
                endcase
            end
            default: ;
        endcase
        if (!run) begin
            ctrl.pcWe  = 1'b0;
            ctrl.irWe  = 1'b0;
            ctrl.regWe = 1'b0;
            ctrl.memWe = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/wordMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module wordMemory #(
    parameter  int MemWords = 256,
    localparam int AddrW    = $clog2(MemWords) + 2 // Byte address width
) (
    input  logic             clk,
    input  logic [AddrW-1:0] addr,
    input  logic [31:0]      wdata,
    input  logic             we,
    input  logic             progWe,
    input  logic [AddrW-1:0] progAddr,
    input  logic [31:0]      progData,
    output logic [31:0]      rdata
);

    logic [31:0] mem [MemWords];

    logic [AddrW-3:0] wordIdx;
    logic [AddrW-3:0] progIdx;

    assign wordIdx = addr[AddrW-1:2];
    assign progIdx = progAddr[AddrW-1:2];

    always_ff @(posedge clk) begin
        if (progWe) begin // Load port wins
            mem[progIdx] <= progData;
        end else if (we) begin
            mem[wordIdx] <= wdata;
        end
    end

    // Same array serves fetch and data
    assign rdata = mem[wordIdx];

endmodule

`default_nettype wire

/* hw/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        we,
    input  logic [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin // x0 writes dropped
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

`default_nettype wire

/* hw/immDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module immDecode import rvPkg::*; (
    input  instrWord_u  instr,
    output logic [31:0] imm
);

    logic isShift;

    // SLLI, SRLI and SRAI carry a shift amount, not a signed immediate
    assign isShift = (instr.r.opcode == OpcOpImm) && (instr.r.funct3[1:0] == 2'b01);

    always_comb begin
        case (instr.r.opcode)
            OpcOpImm: begin
                if (isShift) begin
                    imm = {27'd0, instr.r.rs2};
                end else begin
                    imm = {{20{instr.i.imm[11]}}, instr.i.imm};
                end
            end
            OpcLoad, OpcJalr: imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            OpcStore: imm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
            OpcBranch: begin
                imm = {{20{instr.b.imm12}}, instr.b.imm11, instr.b.imm10to5,
                       instr.b.imm4to1, 1'b0};
            end
            OpcJal: begin
                imm = {{12{instr.j.imm20}}, instr.j.imm19to12, instr.j.imm11,
                       instr.j.imm10to1, 1'b0};
            end
            default: imm = '0; // R format has no immediate
        endcase
    end

endmodule

`default_nettype wire

/* hw/aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module aluUnit import rvPkg::*; (
    input  aluOp_t      op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result,
    output logic        cond
);

    logic [4:0] shamt;
    logic       lessS;
    logic       lessU;

    assign shamt = b[4:0];
    assign lessS = $signed(a) < $signed(b);
    assign lessU = a < b;

    always_comb begin
        case (op)
            AluAdd:  result = a + b;
            AluSub:  result = a - b;
            AluAnd:  result = a & b;
            AluOr:   result = a | b;
            AluXor:  result = a ^ b;
            AluSll:  result = a << shamt;
            AluSrl:  result = a >> shamt;
            AluSra:  result = $unsigned($signed(a) >>> shamt);
            AluSlt:  result = {31'd0, lessS};
            AluSltu: result = {31'd0, lessU};
            default: result = a - b; // Compare ops, result unused
        endcase
    end

    always_comb begin
        case (op)
            AluEq:   cond = (a == b);
            AluNe:   cond = (a != b);
            AluLt:   cond = lessS;
            AluGe:   cond = !lessS;
            AluLtu:  cond = lessU;
            AluGeu:  cond = !lessU;
            default: cond = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/rvPkg.sv */
`default_nettype none

package rvPkg;

    typedef enum logic [1:0] {
        PhaseIf = 2'd0,
        PhaseId = 2'd1,
        PhaseEx = 2'd2,
        PhaseWb = 2'd3
    } phase_t;

    typedef enum logic [6:0] {
        OpcOp     = 7'b0110011,
        OpcOpImm  = 7'b0010011,
        OpcLoad   = 7'b0000011,
        OpcStore  = 7'b0100011,
        OpcBranch = 7'b1100011,
        OpcJal    = 7'b1101111,
        OpcJalr   = 7'b1100111
    } opcode_t;

    typedef enum logic [3:0] {
        AluAdd, AluSub, AluAnd, AluOr, AluXor, AluSll, AluSrl, AluSra,
        AluSlt, AluSltu,
        AluEq, AluNe, AluLt, AluGe, AluLtu, AluGeu // Branch compares, drive cond only
    } aluOp_t;

    // Datapath select encodings
    localparam logic       ASelPc   = 1'b0;
    localparam logic       ASelRs1  = 1'b1;
    localparam logic [1:0] BSelRs2  = 2'd0;
    localparam logic [1:0] BSelImm  = 2'd1;
    localparam logic [1:0] BSelFour = 2'd2;
    localparam logic [1:0] WbAlu    = 2'd0;
    localparam logic [1:0] WbMem    = 2'd1;
    localparam logic [1:0] WbLink   = 2'd2;
    localparam logic       PcSeq    = 1'b0;
    localparam logic       PcTarget = 1'b1;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rType_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iType_t;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sType_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bType_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jType_t;

    typedef union packed {
        rType_t r;
        iType_t i;
        sType_t s;
        bType_t b;
        jType_t j;
    } instrWord_u;

    typedef struct packed {
        logic       pcWe;
        logic       pcSel;
        logic       aSel;
        logic [1:0] bSel;
        aluOp_t     aluOp;
        logic       regWe;
        logic [1:0] wbSel;
        logic       memWe;
        logic       irWe;
        logic       isBranch;
    } ctrlSig_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] nextPc;
        logic        rdWe;
        logic [4:0]  rd;
        logic [31:0] rdData;
        logic        memWe;
        logic        illegal;
    } retireInfo_t;

endpackage

`default_nettype wire
